// File: logic/mul_isa_pkg.sv
// RISC-V M-extension multiply encodings
// Opcode and funct field types, R-type opcode and MULDIV funct7 values
// Decoded multiply op enum, values follow funct3
// Operand sign rules and result word selection per op

package mul_isa_pkg;

  typedef logic [6:0] opcode_t;  // Instruction bits 6:0
  typedef logic [2:0] funct3_t;  // Instruction bits 14:12
  typedef logic [6:0] funct7_t;  // Instruction bits 31:25

  localparam opcode_t OPC_OP    = 7'b0110011;  // R-type register-register ops
  localparam funct7_t F7_MULDIV = 7'b0000001;  // M extension group

  // Low two funct3 bits pick the multiply flavour
  // funct3[2] set belongs to DIV/REM
  typedef enum logic [1:0] {
    OP_MUL    = 2'b00,  // Low word, signed x signed
    OP_MULH   = 2'b01,  // High word, signed x signed
    OP_MULHSU = 2'b10,  // High word, signed x unsigned
    OP_MULHU  = 2'b11   // High word, unsigned x unsigned
  } mul_op_e;

  // rs1 is signed for every op except MULHU
  function automatic logic rs1_signed(input mul_op_e op);
    return (op != OP_MULHU);
  endfunction

  // rs2 is signed only for MUL and MULH
  function automatic logic rs2_signed(input mul_op_e op);
    return (op == OP_MUL) || (op == OP_MULH);
  endfunction

  // Upper 32 bits of the product for all but MUL
  function automatic logic high_word(input mul_op_e op);
    return (op != OP_MUL);
  endfunction

endpackage

// File: logic/mul_sys_pkg.sv
// Multiply subsystem data types
// Register word and accuracy level widths, accuracy cap
// Command struct from the core side
// Job struct from dispatcher to lanes
// Response struct from lanes and collector

package mul_sys_pkg;
  import mul_isa_pkg::*;

  typedef logic [31:0] word_t;  // One integer register
  typedef logic [7:0]  acc_t;   // Accuracy level as held by the core

  // Most low bits that truncation may clear
  localparam acc_t ACC_MAX = 8'd15;

  // Raw instruction fields plus operands, as seen at the command port
  typedef struct packed {
    opcode_t opcode;
    funct3_t funct3;
    funct7_t funct7;
    word_t   rs1;
    word_t   rs2;
    acc_t    accuracy;
  } mul_cmd_t;

  // Decoded work item for one lane
  typedef struct packed {
    mul_op_e op;
    word_t   rs1;
    word_t   rs2;
    acc_t    accuracy;  // Already capped at ACC_MAX
    logic    illegal;   // Not a multiply, lane answers zero
  } mul_job_t;

  // Answer for one command
  typedef struct packed {
    word_t result;
    logic  illegal;
  } mul_rsp_t;

endpackage

// File: logic/mul_dispatch.sv
// Multiply command dispatcher
// Four-phase slave on the command port
// Decode of MUL/MULH/MULHSU/MULHU, illegal detect, accuracy cap
// Strict round-robin issue, stalls on a busy target lane

module mul_dispatch
  import mul_isa_pkg::*;
  import mul_sys_pkg::*;
#(
  parameter int NUM_LANES = 4
) (
  input  logic                 CLK,
  input  logic                 arst_n,
  input  mul_cmd_t             cmd,
  input  logic                 cmd_req,
  output logic                 cmd_ack,
  input  logic [NUM_LANES-1:0] lane_idle,
  output logic [NUM_LANES-1:0] start,
  output mul_job_t             job
);

  localparam int PTR_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

  logic [PTR_W-1:0] issue_ptr;  // Next lane in issue order
  logic             accept;     // New command taken this cycle
  mul_job_t         dec_job;    // Decoded view of cmd

  // Decode, valid whenever cmd_req is high
  always_comb begin
    dec_job.op       = mul_op_e'(cmd.funct3[1:0]);
    dec_job.rs1      = cmd.rs1;
    dec_job.rs2      = cmd.rs2;
    dec_job.accuracy = (cmd.accuracy > ACC_MAX) ? ACC_MAX : cmd.accuracy;
    // Wrong opcode, wrong funct7 or a DIV/REM funct3
    dec_job.illegal  = (cmd.opcode != OPC_OP) || (cmd.funct7 != F7_MULDIV) || cmd.funct3[2];
  end

  // Take a request only once the previous ack has dropped
  assign accept = cmd_req && !cmd_ack && lane_idle[issue_ptr];

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      cmd_ack   <= 1'b0;
      start     <= '0;
      issue_ptr <= '0;
    end else begin
      start <= accept ? (NUM_LANES'(1) << issue_ptr) : '0;  // One-cycle pulse
      if (accept) begin
        cmd_ack <= 1'b1;
        if (issue_ptr == PTR_W'(NUM_LANES - 1)) issue_ptr <= '0;  // Wrap
        else issue_ptr <= issue_ptr + 1'b1;
      end else if (!cmd_req) begin
        cmd_ack <= 1'b0;  // Master released, close the handshake
      end
    end
  end

  // Job register, shared by all lanes and qualified by start
  always_ff @(posedge CLK) begin
    if (accept) job <= dec_job;
  end

  // Only one lane gets a job per cycle
  a_start_onehot : assert property (
    @(posedge CLK) disable iff (!arst_n) $onehot0(start)
  );

  // A lane that is still working never sees start
  a_start_idle : assert property (
    @(posedge CLK) disable iff (!arst_n) (start & ~lane_idle) == '0
  );

endmodule

// File: logic/mul_lane.sv
// Iterative multiplier lane
// Sign handling to magnitudes, optional low-bit truncation
// 32-step shift-add on a 64-bit accumulator
// Final sign fix and low/high word select, result held until take

module mul_lane
  import mul_isa_pkg::*;
  import mul_sys_pkg::*;
#(
  parameter int APPROXIMATE = 0
) (
  input  logic     CLK,
  input  logic     arst_n,
  input  logic     start,
  input  mul_job_t job,
  output logic     idle,
  output logic     done,
  input  logic     take,
  output mul_rsp_t rsp
);

  typedef enum logic [1:0] {
    LANE_IDLE,
    LANE_RUN,
    LANE_DONE
  } lane_state_e;

  lane_state_e state_q;
  logic [4:0]  step_q;     // Shift-add step count
  word_t       mcand_q;    // Multiplicand magnitude
  logic [63:0] acc_q;      // High half partial sum, low half multiplier bits
  logic        neg_q;      // Product must be negated
  logic        high_q;     // Return upper word
  logic        ill_q;      // Illegal job, zero result

  word_t       mag_a;
  word_t       mag_b;
  word_t       keep_mask;  // Ones where operand bits survive
  logic        neg;
  logic [32:0] part_sum;
  logic [63:0] prod;

  // Magnitudes and product sign from the op's sign rules
  always_comb begin
    mag_a = (rs1_signed(job.op) && job.rs1[31]) ? -job.rs1 : job.rs1;
    mag_b = (rs2_signed(job.op) && job.rs2[31]) ? -job.rs2 : job.rs2;
    neg   = (rs1_signed(job.op) && job.rs1[31]) ^ (rs2_signed(job.op) && job.rs2[31]);
    keep_mask = '1;
    if (APPROXIMATE == 1) keep_mask = word_t'('1) << job.accuracy;  // Level 0 keeps all
  end

  // One step: add multiplicand if the current multiplier bit is set
  assign part_sum = {1'b0, acc_q[63:32]} + (acc_q[0] ? {1'b0, mcand_q} : 33'd0);

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= LANE_IDLE;
      step_q  <= '0;
    end else begin
      case (state_q)
        LANE_IDLE: if (start) begin
          state_q <= job.illegal ? LANE_DONE : LANE_RUN;  // Illegal skips the loop
          step_q  <= '0;
        end
        LANE_RUN: begin
          step_q <= step_q + 5'd1;
          if (step_q == 5'd31) state_q <= LANE_DONE;  // Last of 32 steps
        end
        LANE_DONE: if (take) state_q <= LANE_IDLE;
        default:   state_q <= LANE_IDLE;
      endcase
    end
  end

  // Datapath, loaded on start then shifted right each step
  always_ff @(posedge CLK) begin
    if (start) begin
      mcand_q <= mag_a & keep_mask;
      acc_q   <= job.illegal ? 64'd0 : {32'd0, mag_b & keep_mask};
      neg_q   <= neg && !job.illegal;
      high_q  <= high_word(job.op);
      ill_q   <= job.illegal;
    end else if (state_q == LANE_RUN) begin
      acc_q <= {part_sum, acc_q[31:1]};
    end
  end

  assign prod        = neg_q ? -acc_q : acc_q;  // Back to two's complement
  assign rsp.result  = high_q ? prod[63:32] : prod[31:0];
  assign rsp.illegal = ill_q;
  assign idle        = (state_q == LANE_IDLE);
  assign done        = (state_q == LANE_DONE);

  // Collector only takes a finished lane
  a_take_done : assert property (
    @(posedge CLK) disable iff (!arst_n) take |-> state_q == LANE_DONE
  );

  // Legal job finishes exactly 33 cycles after start
  a_legal_latency : assert property (
    @(posedge CLK) disable iff (!arst_n)
    start && !job.illegal |=> !done [*32] ##1 done
  );

endmodule

// File: logic/mul_collect.sv
// Multiply response collector
// Drains lanes round-robin so answers leave in issue order
// Response register and take pulse back to the drained lane
// Four-phase master on the response port

module mul_collect
  import mul_sys_pkg::*;
#(
  parameter int NUM_LANES = 4
) (
  input  logic                 CLK,
  input  logic                 arst_n,
  input  logic [NUM_LANES-1:0] lane_done,
  input  mul_rsp_t             lane_rsp [NUM_LANES],
  output logic [NUM_LANES-1:0] take,
  output mul_rsp_t             rsp,
  output logic                 rsp_req,
  input  logic                 rsp_ack
);

  localparam int PTR_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

  logic [PTR_W-1:0] drain_ptr;  // Oldest lane still owed a response
  logic             load;

  // Port must be fully idle, req and ack both low
  assign load = lane_done[drain_ptr] && !rsp_req && !rsp_ack;

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      rsp_req   <= 1'b0;
      take      <= '0;
      drain_ptr <= '0;
    end else begin
      take <= load ? (NUM_LANES'(1) << drain_ptr) : '0;  // Releases the lane
      if (load) begin
        rsp_req <= 1'b1;
        if (drain_ptr == PTR_W'(NUM_LANES - 1)) drain_ptr <= '0;
        else drain_ptr <= drain_ptr + 1'b1;
      end else if (rsp_ack) begin
        rsp_req <= 1'b0;  // Consumer has it
      end
    end
  end

  // Response payload
  always_ff @(posedge CLK) begin
    if (load) rsp <= lane_rsp[drain_ptr];
  end

  // Payload frozen for the whole request phase
  a_rsp_stable : assert property (
    @(posedge CLK) disable iff (!arst_n) rsp_req |=> !rsp_req || $stable(rsp)
  );

endmodule

// File: logic/mul_unit_top.sv
// Multiply unit top level
// Dispatcher, NUM_LANES iterative lanes, in-order collector
// Four-phase command and response ports

module mul_unit_top
  import mul_sys_pkg::*;
#(
  parameter int NUM_LANES   = 4,
  parameter int APPROXIMATE = 0
) (
  input  logic     CLK,
  input  logic     arst_n,
  input  mul_cmd_t cmd,
  input  logic     cmd_req,
  output logic     cmd_ack,
  output mul_rsp_t rsp,
  output logic     rsp_req,
  input  logic     rsp_ack
);

  logic [NUM_LANES-1:0] lane_idle;
  logic [NUM_LANES-1:0] lane_start;
  logic [NUM_LANES-1:0] lane_done;
  logic [NUM_LANES-1:0] lane_take;
  mul_job_t             job;                   // Broadcast to all lanes
  mul_rsp_t             lane_rsp [NUM_LANES];

  mul_dispatch #(
    .NUM_LANES(NUM_LANES)
  ) u_dispatch (
    .CLK      (CLK),
    .arst_n   (arst_n),
    .cmd      (cmd),
    .cmd_req  (cmd_req),
    .cmd_ack  (cmd_ack),
    .lane_idle(lane_idle),
    .start    (lane_start),
    .job      (job)
  );

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    mul_lane #(
      .APPROXIMATE(APPROXIMATE)
    ) u_lane (
      .CLK   (CLK),
      .arst_n(arst_n),
      .start (lane_start[i]),
      .job   (job),
      .idle  (lane_idle[i]),
      .done  (lane_done[i]),
      .take  (lane_take[i]),
      .rsp   (lane_rsp[i])
    );
  end

  mul_collect #(
    .NUM_LANES(NUM_LANES)
  ) u_collect (
    .CLK      (CLK),
    .arst_n   (arst_n),
    .lane_done(lane_done),
    .lane_rsp (lane_rsp),
    .take     (lane_take),
    .rsp      (rsp),
    .rsp_req  (rsp_req),
    .rsp_ack  (rsp_ack)
  );

endmodule

// File: dv/mul_ref.svh
// Expected response for one multiply command
// Decode check against the R-type MULDIV encodings
// Operand sign rules, low-bit truncation, sign fix and word select in 64 bits
`ifndef MUL_REF_SVH
`define MUL_REF_SVH

function automatic mul_rsp_t expected_rsp(input mul_cmd_t c, input int approx);
  mul_rsp_t    r;
  logic [1:0]  op;
  logic [63:0] a;    // rs1 extended per its sign rule
  logic [63:0] b;
  logic [63:0] ma;   // Magnitudes
  logic [63:0] mb;
  logic [63:0] p;
  int          lvl;  // Low bits to clear
  r  = '0;
  op = c.funct3[1:0];
  if (c.opcode != 7'b0110011 || c.funct7 != 7'b0000001 || c.funct3[2]) begin
    r.illegal = 1'b1;  // Not a multiply, zero result
    return r;
  end
  a   = (op != 2'b11) ? {{32{c.rs1[31]}}, c.rs1} : {32'd0, c.rs1};  // MULHU reads rs1 unsigned
  b   = (op <= 2'b01) ? {{32{c.rs2[31]}}, c.rs2} : {32'd0, c.rs2};  // Signed for MUL, MULH
  lvl = (approx != 0) ? ((c.accuracy > 15) ? 15 : int'(c.accuracy)) : 0;
  ma  = a[63] ? -a : a;
  mb  = b[63] ? -b : b;
  ma  = (ma >> lvl) << lvl;
  mb  = (mb >> lvl) << lvl;
  p   = ma * mb;
  if (a[63] ^ b[63]) p = -p;
  r.result = (op == 2'b00) ? p[31:0] : p[63:32];  // Low word only for MUL
  return r;
endfunction

`endif

// File: dv/mul_unit_tb.sv
// Testbench for the multiply unit
// Clock and reset, four-phase command driver and response consumer
// Queue of expected responses checked in order, watchdog and report

module mul_unit_tb
  import mul_isa_pkg::*;
  import mul_sys_pkg::*;
();

  `include "mul_ref.svh"

  localparam int NUM_LANES   = 4;
  localparam int APPROXIMATE = 1;
  localparam int N_EXACT     = 64 + 16;  // Corner grid plus random operands
  localparam int N_APPROX    = 32;
  localparam int N_ILLEGAL   = 12;
  localparam int N_BURST     = 24;
  localparam int N_STALL     = 10;
  localparam int TOTAL_CMDS  = N_EXACT + N_APPROX + N_ILLEGAL + N_BURST + N_STALL;

  logic     CLK;
  logic     arst_n;
  mul_cmd_t cmd;
  logic     cmd_req;
  logic     cmd_ack;
  mul_rsp_t rsp;
  logic     rsp_req;
  logic     rsp_ack;

  integer   seed     = 16510;  // Stimulus stream
  integer   ack_seed = 16510;  // Consumer delay stream
  mul_rsp_t exp_q [$];         // One entry per accepted command
  int       errors, checks, tests_run, tests_failed;
  int       cmd_count, rsp_count, max_in_flight, max_wait;
  int       ack_min, ack_max;  // Consumer delay range in cycles
  word_t    corner [4] = '{32'h0000_0000, 32'hFFFF_FFFF, 32'h8000_0000, 32'h7FFF_FFFF};

  mul_unit_top #(
    .NUM_LANES  (NUM_LANES),
    .APPROXIMATE(APPROXIMATE)
  ) dut0 (
    .CLK    (CLK),
    .arst_n (arst_n),
    .cmd    (cmd),
    .cmd_req(cmd_req),
    .cmd_ack(cmd_ack),
    .rsp    (rsp),
    .rsp_req(rsp_req),
    .rsp_ack(rsp_ack)
  );

  always #5 CLK = ~CLK;

  function automatic int rand_below(input int n);
    return {$random(seed)} % n;
  endfunction

  function automatic mul_cmd_t make_cmd(input int op, input word_t a, input word_t b,
                                        input int acc);
    mul_cmd_t c;
    c.opcode   = OPC_OP;
    c.funct3   = 3'(op);
    c.funct7   = F7_MULDIV;
    c.rs1      = a;
    c.rs2      = b;
    c.accuracy = acc_t'(acc);
    return c;
  endfunction

  // Four-phase master, one command from request to ack low
  task automatic send_cmd(input mul_cmd_t c);
    int wait_cycles;
    wait_cycles = 0;
    cmd     <= c;
    cmd_req <= 1'b1;
    do begin
      @(posedge CLK);
      wait_cycles++;
    end while (!cmd_ack);
    exp_q.push_back(expected_rsp(c, APPROXIMATE));  // Accepted, owed a response
    cmd_count++;
    if (exp_q.size() > max_in_flight) max_in_flight = exp_q.size();
    if (wait_cycles > max_wait) max_wait = wait_cycles;
    cmd_req <= 1'b0;
    do @(posedge CLK); while (cmd_ack);
  endtask

  // Waits for every response to drain, then reports the test
  task automatic finish_test(input string name, input int err_before);
    do @(posedge CLK); while (exp_q.size() != 0 || rsp_req || rsp_ack);
    tests_run++;
    if (errors != err_before) tests_failed++;
    $display("Test %0d %s finished with %0d errors", tests_run, name, errors - err_before);
  endtask

  // Consumer side of the response handshake
  initial begin : ack_rsp
    int delay;
    wait (arst_n);  // Port is idle until reset is released
    forever begin
      do @(posedge CLK); while (!rsp_req);
      delay = ack_min + {$random(ack_seed)} % (ack_max - ack_min + 1);
      repeat (delay) @(posedge CLK);
      rsp_ack <= 1'b1;
      do @(posedge CLK); while (rsp_req);
      rsp_ack <= 1'b0;
    end
  end

  // Pops the oldest expected value on each new response
  initial begin : compare_rsp
    logic     req_seen;
    mul_rsp_t exp_rsp;
    req_seen = 1'b0;
    forever begin
      @(posedge CLK);
      if (rsp_req && !req_seen) begin
        rsp_count++;
        if (exp_q.size() == 0) begin
          errors++;
          $display("Response at time %0t arrived with no command outstanding", $time);
        end else begin
          exp_rsp = exp_q.pop_front();
          checks++;
          assert (rsp == exp_rsp) else begin
            errors++;
            $display("Fail %0t: got result %h illegal %b, expected result %h illegal %b",
                     $time, rsp.result, rsp.illegal, exp_rsp.result, exp_rsp.illegal);
          end
        end
      end
      req_seen = rsp_req;
    end
  end

  initial begin : watchdog
    repeat (TOTAL_CMDS * 60 + 10) @(posedge CLK);  // 60 cycles per command
    $display("Timeout, the run stopped after %0d commands and %0d responses",
             cmd_count, rsp_count);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    int       err0;
    mul_cmd_t c;
    CLK     = 1'b0;
    arst_n  = 1'b0;
    cmd     = '0;
    cmd_req = 1'b0;
    rsp_ack = 1'b0;
    ack_min = 0;
    ack_max = 40;
    repeat (3) @(posedge CLK);
    arst_n <= 1'b1;
    @(posedge CLK);

    err0 = errors;  // Exact products on corners and random words
    for (int op = 0; op < 4; op++)
      for (int i = 0; i < 4; i++)
        for (int j = 0; j < 4; j++) send_cmd(make_cmd(op, corner[i], corner[j], 0));
    for (int k = 0; k < 16; k++)
      send_cmd(make_cmd(rand_below(4), $random(seed), $random(seed), 0));
    finish_test("exact ops", err0);

    err0 = errors;  // Truncated operands, level capped at 15
    for (int k = 0; k < N_APPROX; k++)
      send_cmd(make_cmd(rand_below(4), $random(seed), $random(seed), 1 + rand_below(255)));
    finish_test("approximate", err0);

    err0 = errors;  // Illegal encodings mixed with legal ones
    for (int k = 0; k < N_ILLEGAL; k++) begin
      c = make_cmd(rand_below(4), $random(seed), $random(seed), rand_below(20));
      case (k % 4)
        0: c.opcode = (c.opcode ^ opcode_t'(1 + rand_below(127)));  // Never OPC_OP
        1: c.funct7 = (c.funct7 ^ funct7_t'(1 + rand_below(127)));
        3: c.funct3 = 3'(4 + rand_below(4));                        // DIV/REM group
        default: ;
      endcase
      send_cmd(c);
    end
    finish_test("illegal", err0);

    err0 = errors;  // Back-to-back with a fast consumer
    ack_max       = 2;
    max_in_flight = 0;
    for (int k = 0; k < N_BURST; k++)
      send_cmd(make_cmd(rand_below(4), $random(seed), $random(seed), rand_below(20)));
    assert (max_in_flight >= 3) else begin
      errors++;
      $display("The burst never kept more than %0d commands in flight", max_in_flight);
    end
    finish_test("burst", err0);

    err0 = errors;  // Slow consumer fills every lane
    ack_min  = 50;
    ack_max  = 50;
    max_wait = 0;
    for (int k = 0; k < N_STALL; k++)
      send_cmd(make_cmd(rand_below(4), $random(seed), $random(seed), rand_below(20)));
    assert (max_wait > 33) else begin
      errors++;
      $display("The command port never stalled while the lanes were full");
    end
    finish_test("back-pressure", err0);

    assert (rsp_count == cmd_count) else begin
      errors++;
      $display("Saw %0d responses for %0d commands", rsp_count, cmd_count);
    end
    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) $display("TEST OK");
    else $display("TEST FAILED");
    $finish;
  end

endmodule

// File: compile.f
+incdir+dv
logic/mul_isa_pkg.sv
logic/mul_sys_pkg.sv
logic/mul_dispatch.sv
logic/mul_lane.sv
logic/mul_collect.sv
logic/mul_unit_top.sv
dv/mul_unit_tb.sv

// File: Bender.yml
package:
  name: mul_unit

sources:
  - logic/mul_isa_pkg.sv
  - logic/mul_sys_pkg.sv
  - logic/mul_dispatch.sv
  - logic/mul_lane.sv
  - logic/mul_collect.sv
  - logic/mul_unit_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/mul_unit_tb.sv
